/* common/decode_macros.svh */
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// datapath and address width
`define DATA_W     32

// register numbers
`define REG_W      5
`define REG_NUM    32
`define RA_REG     31      // link register for jal

// instruction field geometry
`define IMM_W      16
`define IDX_W      26      // jump index
`define SHAMT_LSB  6
`define OP_LSB     26      // opcode sits in [31:26]
`define FUNCT_W    6

`endif

/* common/decode_pkg.sv */
`include "decode_macros.svh"

package decode_pkg;

   // primary opcode field, instr[31:26]
   typedef enum logic [`FUNCT_W-1:0] {
      OP_SPECIAL = 6'd0,
      OP_J       = 6'd2,
      OP_JAL     = 6'd3,
      OP_BEQ     = 6'd4,
      OP_BNE     = 6'd5,
      OP_ADDI    = 6'd8,
      OP_SLTI    = 6'd10,
      OP_ANDI    = 6'd12,
      OP_ORI     = 6'd13,
      OP_XORI    = 6'd14,
      OP_LUI     = 6'd15,
      OP_LW      = 6'd35,
      OP_SW      = 6'd43
   } opcode_e;

   // function codes of the SPECIAL group that decode looks at
   typedef enum logic [`FUNCT_W-1:0] {
      FN_SLL  = 6'd0,
      FN_SRL  = 6'd2,
      FN_SRA  = 6'd3,
      FN_JR   = 6'd8,
      FN_JALR = 6'd9
   } funct_e;

   typedef enum logic [3:0] {
      ALU_NONE,
      ALU_ADD,
      ALU_SLT,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_LUI,
      ALU_JAL,
      ALU_FUNC   // execute decodes the function field
   } alu_op_e;

   typedef enum logic [1:0] {SRC_A_PC, SRC_A_RS, SRC_A_IMM, SRC_A_NONE} src_a_e;

   typedef enum logic {SRC_B_RT, SRC_B_IMM} src_b_e;

   typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_RA} dest_sel_e;

   typedef enum logic [1:0] {EXT_JUMP, EXT_SIGN, EXT_ZERO, EXT_SHAMT} ext_kind_e;

endpackage

/* logic/reg_file.sv */
`include "decode_macros.svh"

module reg_file (
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic [`REG_W-1:0]  i_rd_addr_a,
   input  logic [`REG_W-1:0]  i_rd_addr_b,
   input  logic [`REG_W-1:0]  i_wr_addr,
   input  logic [`DATA_W-1:0] i_wr_data,
   input  logic              i_wr_en,
   output logic [`DATA_W-1:0] o_rd_data_a,
   output logic [`DATA_W-1:0] o_rd_data_b,
   output logic              o_equal
);

   logic [`DATA_W-1:0] regs [`REG_NUM];

   // register 0 is never written
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < `REG_NUM; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wr_en && (i_wr_addr != '0)) begin
         regs[i_wr_addr] <= i_wr_data;
      end
   end

   // no bypass, a same-cycle write shows up next cycle
   assign o_rd_data_a = (i_rd_addr_a == '0) ? '0 : regs[i_rd_addr_a];
   assign o_rd_data_b = (i_rd_addr_b == '0) ? '0 : regs[i_rd_addr_b];

   assign o_equal = (o_rd_data_a == o_rd_data_b);  // beq/bne compare

endmodule

/* decode/decode_control.sv */
`include "decode_macros.svh"

module decode_control (
   input  logic [`DATA_W-1:0]    i_instr,
   output decode_pkg::ext_kind_e o_ext_kind,
   output decode_pkg::alu_op_e   o_alu_op,
   output decode_pkg::src_a_e    o_src_a,
   output decode_pkg::src_b_e    o_src_b,
   output decode_pkg::dest_sel_e o_dest_sel,
   output logic                  o_is_beq,
   output logic                  o_is_bne,
   output logic                  o_jmp_from_reg,
   output logic                  o_pc_jump,
   output logic                  o_mem_rd,
   output logic                  o_mem_wr,
   output logic                  o_wb_en,
   output logic                  o_wb_from_mem
);

   decode_pkg::opcode_e opcode;
   decode_pkg::funct_e  funct;
   logic                reg_jump;

   assign opcode = decode_pkg::opcode_e'(i_instr[`DATA_W-1:`OP_LSB]);
   assign funct  = decode_pkg::funct_e'(i_instr[`FUNCT_W-1:0]);

   assign reg_jump = (funct == decode_pkg::FN_JR) || (funct == decode_pkg::FN_JALR);

   always_comb begin
      // everything starts as a nop
      o_ext_kind     = decode_pkg::EXT_SIGN;
      o_alu_op       = decode_pkg::ALU_NONE;
      o_src_a        = decode_pkg::SRC_A_NONE;
      o_src_b        = decode_pkg::SRC_B_IMM;
      o_dest_sel     = decode_pkg::DEST_RD;
      o_is_beq       = 1'b0;
      o_is_bne       = 1'b0;
      o_jmp_from_reg = 1'b0;
      o_pc_jump      = 1'b0;
      o_mem_rd       = 1'b0;
      o_mem_wr       = 1'b0;
      o_wb_en        = 1'b0;
      o_wb_from_mem  = 1'b0;

      // the immediate group, loads and stores all take rs as operand a
      case (opcode)
         decode_pkg::OP_ADDI, decode_pkg::OP_SLTI, decode_pkg::OP_ANDI,
         decode_pkg::OP_ORI, decode_pkg::OP_XORI, decode_pkg::OP_LW,
         decode_pkg::OP_SW: o_src_a = decode_pkg::SRC_A_RS;
         default: ;
      endcase

      case (opcode)
         decode_pkg::OP_J: begin
            o_ext_kind = decode_pkg::EXT_JUMP;
            o_pc_jump  = 1'b1;
         end
         decode_pkg::OP_JAL: begin
            o_ext_kind = decode_pkg::EXT_JUMP;
            o_alu_op   = decode_pkg::ALU_JAL;
            o_src_a    = decode_pkg::SRC_A_PC;   // return address from pc
            o_dest_sel = decode_pkg::DEST_RA;
            o_pc_jump  = 1'b1;
            o_wb_en    = 1'b1;
         end
         decode_pkg::OP_BEQ: o_is_beq = 1'b1;
         decode_pkg::OP_BNE: o_is_bne = 1'b1;
         decode_pkg::OP_ADDI, decode_pkg::OP_SLTI, decode_pkg::OP_ANDI,
         decode_pkg::OP_ORI, decode_pkg::OP_XORI, decode_pkg::OP_LUI: begin
            o_dest_sel = decode_pkg::DEST_RT;
            o_wb_en    = 1'b1;
            case (opcode)
               decode_pkg::OP_ADDI: o_alu_op = decode_pkg::ALU_ADD;
               decode_pkg::OP_SLTI: o_alu_op = decode_pkg::ALU_SLT;
               decode_pkg::OP_ANDI: o_alu_op = decode_pkg::ALU_AND;
               decode_pkg::OP_ORI:  o_alu_op = decode_pkg::ALU_OR;
               decode_pkg::OP_XORI: o_alu_op = decode_pkg::ALU_XOR;
               default:             o_alu_op = decode_pkg::ALU_LUI;
            endcase
            // logical ops and lui see the raw 16 bits
            if (opcode != decode_pkg::OP_ADDI && opcode != decode_pkg::OP_SLTI) begin
               o_ext_kind = decode_pkg::EXT_ZERO;
            end
         end
         decode_pkg::OP_LW: begin
            o_alu_op      = decode_pkg::ALU_ADD;  // base + offset
            o_dest_sel    = decode_pkg::DEST_RT;
            o_mem_rd      = 1'b1;
            o_wb_en       = 1'b1;
            o_wb_from_mem = 1'b1;
         end
         decode_pkg::OP_SW: begin
            o_alu_op   = decode_pkg::ALU_ADD;
            o_dest_sel = decode_pkg::DEST_RT;
            o_mem_wr   = 1'b1;
         end
         decode_pkg::OP_SPECIAL: begin
            o_ext_kind     = decode_pkg::EXT_SHAMT;
            o_alu_op       = decode_pkg::ALU_FUNC;
            o_src_b        = decode_pkg::SRC_B_RT;
            o_jmp_from_reg = reg_jump;
            o_pc_jump      = reg_jump;
            case (funct)
               decode_pkg::FN_JALR: o_src_a = decode_pkg::SRC_A_PC;
               decode_pkg::FN_SLL, decode_pkg::FN_SRL,
               decode_pkg::FN_SRA:  o_src_a = decode_pkg::SRC_A_IMM;  // shamt
               default:             o_src_a = decode_pkg::SRC_A_RS;
            endcase
            // jr links nothing, all-zero word is the nop
            o_wb_en = !((funct == decode_pkg::FN_JR) || (i_instr == '0));
         end
         default: ;  // unknown opcode stays a nop
      endcase
   end

endmodule

/* decode/imm_extend.sv */
`include "decode_macros.svh"

module imm_extend (
   input  logic [`DATA_W-1:0]    i_instr,
   input  decode_pkg::ext_kind_e i_ext_kind,
   output logic [`DATA_W-1:0]    o_imm
);

   logic [`IMM_W-1:0] imm16;
   logic [`REG_W-1:0] shamt;

   assign imm16 = i_instr[`IMM_W-1:0];
   assign shamt = i_instr[`SHAMT_LSB+`REG_W-1:`SHAMT_LSB];

   always_comb begin
      case (i_ext_kind)
         decode_pkg::EXT_JUMP: o_imm = {{(`DATA_W-`IDX_W){1'b0}}, i_instr[`IDX_W-1:0]};
         decode_pkg::EXT_SIGN: o_imm = {{(`DATA_W-`IMM_W){imm16[`IMM_W-1]}}, imm16};
         decode_pkg::EXT_ZERO: o_imm = {{(`DATA_W-`IMM_W){1'b0}}, imm16};
         default:              o_imm = {{(`DATA_W-`REG_W){1'b0}}, shamt};  // shifts
      endcase
   end

endmodule

/* decode/branch_target.sv */
`include "decode_macros.svh"

module branch_target (
   input  logic [`DATA_W-1:0] i_pc,
   input  logic [`DATA_W-1:0] i_imm,
   input  logic [`DATA_W-1:0] i_rs_value,
   input  logic              i_equal,
   input  logic              i_is_beq,
   input  logic              i_is_bne,
   input  logic              i_jmp_from_reg,
   output logic [`DATA_W-1:0] o_brh_addr,
   output logic [`DATA_W-1:0] o_jmp_addr,
   output logic              o_pc_branch
);

   logic [`DATA_W-1:0] offset;

   // word offset to byte offset, sign kept by the extender
   assign offset = {i_imm[`DATA_W-3:0], 2'b00};

   // relative to the pc as given, no +4 here
   assign o_brh_addr = $unsigned($signed(i_pc) + $signed(offset));

   // jr/jalr take rs, j/jal splice the index into the current region
   always_comb begin
      if (i_jmp_from_reg) begin
         o_jmp_addr = i_rs_value;
      end else begin
         o_jmp_addr = {i_pc[`DATA_W-1:`IDX_W+2], i_imm[`IDX_W-1:0], 2'b00};
      end
   end

   assign o_pc_branch = (i_is_beq & i_equal) | (i_is_bne & ~i_equal);

endmodule

/* decode/id_ex_latch.sv */
`include "decode_macros.svh"

module id_ex_latch (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic [`DATA_W-1:0]     i_pc,
   input  logic [`DATA_W-1:0]     i_rs,
   input  logic [`DATA_W-1:0]     i_rt,
   input  logic [`DATA_W-1:0]     i_imm,
   input  logic [`REG_W-1:0]      i_rs_num,
   input  logic [`REG_W-1:0]      i_rt_num,
   input  logic [`REG_W-1:0]      i_rd_num,
   input  logic [`FUNCT_W-1:0]    i_funct,
   input  decode_pkg::alu_op_e   i_alu_op,
   input  decode_pkg::src_a_e    i_src_a,
   input  decode_pkg::src_b_e    i_src_b,
   input  decode_pkg::dest_sel_e i_dest_sel,
   input  logic                  i_mem_rd,
   input  logic                  i_mem_wr,
   input  logic                  i_wb_en,
   input  logic                  i_wb_from_mem,
   output logic [`DATA_W-1:0]     o_ex_pc,
   output logic [`DATA_W-1:0]     o_ex_rs,
   output logic [`DATA_W-1:0]     o_ex_rt,
   output logic [`DATA_W-1:0]     o_ex_imm,
   output logic [`REG_W-1:0]      o_ex_rs_num,
   output logic [`REG_W-1:0]      o_ex_rt_num,
   output logic [`REG_W-1:0]      o_ex_rd_num,
   output logic [`FUNCT_W-1:0]    o_ex_funct,
   output decode_pkg::alu_op_e   o_ex_alu_op,
   output decode_pkg::src_a_e    o_ex_src_a,
   output decode_pkg::src_b_e    o_ex_src_b,
   output decode_pkg::dest_sel_e o_ex_dest_sel,
   output logic                  o_ex_mem_rd,
   output logic                  o_ex_mem_wr,
   output logic                  o_ex_wb_en,
   output logic                  o_ex_wb_from_mem
);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         // all-zero bubble, nothing enabled downstream
         o_ex_pc          <= '0;
         o_ex_rs          <= '0;
         o_ex_rt          <= '0;
         o_ex_imm         <= '0;
         o_ex_rs_num      <= '0;
         o_ex_rt_num      <= '0;
         o_ex_rd_num      <= '0;
         o_ex_funct       <= '0;
         o_ex_alu_op      <= decode_pkg::ALU_NONE;
         o_ex_src_a       <= decode_pkg::SRC_A_PC;
         o_ex_src_b       <= decode_pkg::SRC_B_RT;
         o_ex_dest_sel    <= decode_pkg::DEST_RD;
         o_ex_mem_rd      <= 1'b0;
         o_ex_mem_wr      <= 1'b0;
         o_ex_wb_en       <= 1'b0;
         o_ex_wb_from_mem <= 1'b0;
      end else begin
         o_ex_pc          <= i_pc;
         o_ex_rs          <= i_rs;
         o_ex_rt          <= i_rt;
         o_ex_imm         <= i_imm;
         o_ex_rs_num      <= i_rs_num;
         o_ex_rt_num      <= i_rt_num;
         o_ex_rd_num      <= i_rd_num;
         o_ex_funct       <= i_funct;
         o_ex_alu_op      <= i_alu_op;
         o_ex_src_a       <= i_src_a;
         o_ex_src_b       <= i_src_b;
         o_ex_dest_sel    <= i_dest_sel;
         o_ex_mem_rd      <= i_mem_rd;
         o_ex_mem_wr      <= i_mem_wr;
         o_ex_wb_en       <= i_wb_en;
         o_ex_wb_from_mem <= i_wb_from_mem;
      end
   end

endmodule

/* decode/decode_stage.sv */
`include "decode_macros.svh"

module decode_stage (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic [`DATA_W-1:0]     i_pc,
   input  logic [`DATA_W-1:0]     i_instr,
   input  logic [`DATA_W-1:0]     i_wb_data,
   input  logic [`REG_W-1:0]      i_wb_dst,
   input  logic                  i_wb_en,
   output logic [`DATA_W-1:0]     o_brh_addr,
   output logic [`DATA_W-1:0]     o_jmp_addr,
   output logic                  o_pc_branch,
   output logic                  o_pc_jump,
   output logic [`DATA_W-1:0]     o_ex_pc,
   output logic [`DATA_W-1:0]     o_ex_rs,
   output logic [`DATA_W-1:0]     o_ex_rt,
   output logic [`DATA_W-1:0]     o_ex_imm,
   output logic [`REG_W-1:0]      o_ex_rs_num,
   output logic [`REG_W-1:0]      o_ex_rt_num,
   output logic [`REG_W-1:0]      o_ex_rd_num,
   output logic [`FUNCT_W-1:0]    o_ex_funct,
   output decode_pkg::alu_op_e   o_ex_alu_op,
   output decode_pkg::src_a_e    o_ex_src_a,
   output decode_pkg::src_b_e    o_ex_src_b,
   output decode_pkg::dest_sel_e o_ex_dest_sel,
   output logic                  o_ex_mem_rd,
   output logic                  o_ex_mem_wr,
   output logic                  o_ex_wb_en,
   output logic                  o_ex_wb_from_mem
);

   decode_pkg::ext_kind_e ext_kind;
   decode_pkg::alu_op_e   alu_op;
   decode_pkg::src_a_e    src_a;
   decode_pkg::src_b_e    src_b;
   decode_pkg::dest_sel_e dest_sel;
   logic                  is_beq;
   logic                  is_bne;
   logic                  jmp_from_reg;
   logic                  mem_rd;
   logic                  mem_wr;
   logic                  wb_en;
   logic                  wb_from_mem;
   logic [`DATA_W-1:0]     rs_value;
   logic [`DATA_W-1:0]     rt_value;
   logic                  rf_equal;
   logic [`DATA_W-1:0]     imm;

   decode_control u_control (
      .i_instr        (i_instr),
      .o_ext_kind     (ext_kind),
      .o_alu_op       (alu_op),
      .o_src_a        (src_a),
      .o_src_b        (src_b),
      .o_dest_sel     (dest_sel),
      .o_is_beq       (is_beq),
      .o_is_bne       (is_bne),
      .o_jmp_from_reg (jmp_from_reg),
      .o_pc_jump      (o_pc_jump),
      .o_mem_rd       (mem_rd),
      .o_mem_wr       (mem_wr),
      .o_wb_en        (wb_en),
      .o_wb_from_mem  (wb_from_mem)
   );

   reg_file u_reg_file (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_rd_addr_a (i_instr[`OP_LSB-1:`OP_LSB-`REG_W]),       // rs
      .i_rd_addr_b (i_instr[`OP_LSB-`REG_W-1:`IMM_W]),        // rt
      .i_wr_addr   (i_wb_dst),
      .i_wr_data   (i_wb_data),
      .i_wr_en     (i_wb_en),
      .o_rd_data_a (rs_value),
      .o_rd_data_b (rt_value),
      .o_equal     (rf_equal)
   );

   imm_extend u_imm_extend (
      .i_instr    (i_instr),
      .i_ext_kind (ext_kind),
      .o_imm      (imm)
   );

   branch_target u_branch_target (
      .i_pc           (i_pc),
      .i_imm          (imm),
      .i_rs_value     (rs_value),
      .i_equal        (rf_equal),
      .i_is_beq       (is_beq),
      .i_is_bne       (is_bne),
      .i_jmp_from_reg (jmp_from_reg),
      .o_brh_addr     (o_brh_addr),
      .o_jmp_addr     (o_jmp_addr),
      .o_pc_branch    (o_pc_branch)
   );

   id_ex_latch u_id_ex (
      .i_clk            (i_clk),
      .i_rst            (i_rst),
      .i_pc             (i_pc),
      .i_rs             (rs_value),
      .i_rt             (rt_value),
      .i_imm            (imm),
      .i_rs_num         (i_instr[`OP_LSB-1:`OP_LSB-`REG_W]),
      .i_rt_num         (i_instr[`OP_LSB-`REG_W-1:`IMM_W]),
      .i_rd_num         (i_instr[`IMM_W-1:`IMM_W-`REG_W]),    // rd in [15:11]
      .i_funct          (i_instr[`FUNCT_W-1:0]),
      .i_alu_op         (alu_op),
      .i_src_a          (src_a),
      .i_src_b          (src_b),
      .i_dest_sel       (dest_sel),
      .i_mem_rd         (mem_rd),
      .i_mem_wr         (mem_wr),
      .i_wb_en          (wb_en),
      .i_wb_from_mem    (wb_from_mem),
      .o_ex_pc          (o_ex_pc),
      .o_ex_rs          (o_ex_rs),
      .o_ex_rt          (o_ex_rt),
      .o_ex_imm         (o_ex_imm),
      .o_ex_rs_num      (o_ex_rs_num),
      .o_ex_rt_num      (o_ex_rt_num),
      .o_ex_rd_num      (o_ex_rd_num),
      .o_ex_funct       (o_ex_funct),
      .o_ex_alu_op      (o_ex_alu_op),
      .o_ex_src_a       (o_ex_src_a),
      .o_ex_src_b       (o_ex_src_b),
      .o_ex_dest_sel    (o_ex_dest_sel),
      .o_ex_mem_rd      (o_ex_mem_rd),
      .o_ex_mem_wr      (o_ex_mem_wr),
      .o_ex_wb_en       (o_ex_wb_en),
      .o_ex_wb_from_mem (o_ex_wb_from_mem)
   );

endmodule

/* testbench/decode_props.sv */
`include "decode_macros.svh"

module decode_props (
   input logic i_clk,
   input logic i_rst,
   input logic i_pc_branch,
   input logic i_pc_jump,
   input logic i_mem_rd,
   input logic i_mem_wr,
   input logic i_wb_en,
   input logic i_wb_from_mem
);
   timeunit 1ns;
   timeprecision 1ps;

   int unsigned fail_cnt = 0;   // read by the testbench at the end

   // one redirect kind per instruction
   a_one_redirect: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_pc_branch && i_pc_jump))
      else begin
         fail_cnt++;
         $error("branch and jump redirect are high in the same cycle");
      end

   a_one_mem_op: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_mem_rd && i_mem_wr))
      else begin
         fail_cnt++;
         $error("memory read and memory write are latched together");
      end

   // reset leaves an inactive bubble in the ID/EX latch
   a_reset_bubble: assert property (@(posedge i_clk)
      i_rst |=> !(i_mem_rd || i_mem_wr || i_wb_en || i_wb_from_mem))
      else begin
         fail_cnt++;
         $error("a latched enable is high in the cycle after reset");
      end

endmodule

bind decode_stage decode_props u_props (
   .i_clk         (i_clk),
   .i_rst         (i_rst),
   .i_pc_branch   (o_pc_branch),
   .i_pc_jump     (o_pc_jump),
   .i_mem_rd      (o_ex_mem_rd),
   .i_mem_wr      (o_ex_mem_wr),
   .i_wb_en       (o_ex_wb_en),
   .i_wb_from_mem (o_ex_wb_from_mem)
);

/* testbench/tb_decode.sv */
`include "decode_macros.svh"

module tb_decode;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int LATCH_TIMEOUT = 8;   // cycles

   logic                  i_clk;
   logic                  i_rst;
   logic [`DATA_W-1:0]    i_pc;
   logic [`DATA_W-1:0]    i_instr;
   logic [`DATA_W-1:0]    i_wb_data;
   logic [`REG_W-1:0]     i_wb_dst;
   logic                  i_wb_en;
   logic [`DATA_W-1:0]    o_brh_addr;
   logic [`DATA_W-1:0]    o_jmp_addr;
   logic                  o_pc_branch;
   logic                  o_pc_jump;
   logic [`DATA_W-1:0]    o_ex_pc;
   logic [`DATA_W-1:0]    o_ex_rs;
   logic [`DATA_W-1:0]    o_ex_rt;
   logic [`DATA_W-1:0]    o_ex_imm;
   logic [`REG_W-1:0]     o_ex_rs_num;
   logic [`REG_W-1:0]     o_ex_rt_num;
   logic [`REG_W-1:0]     o_ex_rd_num;
   logic [`FUNCT_W-1:0]   o_ex_funct;
   decode_pkg::alu_op_e   o_ex_alu_op;
   decode_pkg::src_a_e    o_ex_src_a;
   decode_pkg::src_b_e    o_ex_src_b;
   decode_pkg::dest_sel_e o_ex_dest_sel;
   logic                  o_ex_mem_rd;
   logic                  o_ex_mem_wr;
   logic                  o_ex_wb_en;
   logic                  o_ex_wb_from_mem;

   string       test_name;
   int          value_errs;
   int          timing_errs;
   int          prop_errs;
   logic [31:0] pc_seq;

   decode_stage u_dut (.*);

   initial begin
      i_clk = 1'b0;
      forever #10 i_clk = ~i_clk;
   end

   function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [4:0] shamt,
                                         input logic [5:0] funct);
      return {6'd0, rs, rt, rd, shamt, funct};
   endfunction

   function automatic logic [31:0] sext16(input logic [15:0] imm);
      return {{16{imm[15]}}, imm};
   endfunction

   // unique pc per instruction, marks it in the latch
   function automatic logic [31:0] next_pc();
      pc_seq = pc_seq + 32'd4;
      return pc_seq;
   endfunction

   task automatic check_eq(input string field, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else begin
         value_errs++;
         $display("ERR %s %s: expected %h, actual %h", test_name, field, exp, act);
      end
   endtask

   task automatic write_reg(input logic [4:0] num, input logic [31:0] val);
      i_wb_dst  = num;
      i_wb_data = val;
      i_wb_en   = 1'b1;
      @(negedge i_clk);
      i_wb_en   = 1'b0;
   endtask

   task automatic issue(input logic [31:0] instr, input logic [31:0] pc);
      i_instr = instr;
      i_pc    = pc;
      #1;   // let the combinational redirect settle
   endtask

   task automatic wait_latch(input logic [31:0] pc);
      int cycles;
      cycles = 0;
      do begin
         @(negedge i_clk);
         cycles++;
      end while (o_ex_pc !== pc && cycles < LATCH_TIMEOUT);
      if (o_ex_pc !== pc) begin
         timing_errs++;
         $display("timeout in %s: pc %h never reached the ID/EX latch", test_name, pc);
      end else begin
         assert (cycles == 1)
         else begin
            timing_errs++;
            $display("%s: pc %h reached the latch after %0d cycles", test_name, pc, cycles);
         end
      end
   endtask

   task automatic reset_check();
      logic [31:0] pc;
      test_name = "reset";
      check_eq("pc", 32'd0, o_ex_pc);
      check_eq("rs", 32'd0, o_ex_rs);
      check_eq("rt", 32'd0, o_ex_rt);
      check_eq("imm", 32'd0, o_ex_imm);
      check_eq("fields", 32'd0, 32'({o_ex_rs_num, o_ex_rt_num, o_ex_rd_num, o_ex_funct}));
      check_eq("controls", 32'd0, 32'({o_ex_alu_op, o_ex_src_a, o_ex_src_b, o_ex_dest_sel,
                                      o_ex_mem_rd, o_ex_mem_wr, o_ex_wb_en, o_ex_wb_from_mem}));
      i_rst = 1'b0;
      write_reg(5'd0, $urandom() | 32'd1);   // must not stick
      pc = next_pc();
      issue(enc_i(decode_pkg::OP_ADDI, 5'd0, 5'd0, 16'h0001), pc);
      wait_latch(pc);
      check_eq("r0 value", 32'd0, o_ex_rs);
   endtask

   task automatic imm_alu_ops();
      decode_pkg::opcode_e ops [6] = '{decode_pkg::OP_ADDI, decode_pkg::OP_SLTI,
         decode_pkg::OP_ANDI, decode_pkg::OP_ORI, decode_pkg::OP_XORI, decode_pkg::OP_LUI};
      decode_pkg::alu_op_e exp_alu;
      decode_pkg::src_a_e  exp_src_a;
      logic [31:0] v5;
      logic [31:0] v6;
      logic [31:0] pc;
      logic [31:0] exp_imm;
      logic [15:0] imm;
      v5 = $urandom();
      v6 = $urandom();
      write_reg(5'd5, v5);
      write_reg(5'd6, v6);
      foreach (ops[k]) begin
         test_name = $sformatf("imm_ops %s", ops[k].name());
         imm = 16'($urandom());
         pc  = next_pc();
         case (ops[k])
            decode_pkg::OP_ADDI: exp_alu = decode_pkg::ALU_ADD;
            decode_pkg::OP_SLTI: exp_alu = decode_pkg::ALU_SLT;
            decode_pkg::OP_ANDI: exp_alu = decode_pkg::ALU_AND;
            decode_pkg::OP_ORI:  exp_alu = decode_pkg::ALU_OR;
            decode_pkg::OP_XORI: exp_alu = decode_pkg::ALU_XOR;
            default:             exp_alu = decode_pkg::ALU_LUI;
         endcase
         // only the arithmetic pair sign-extends
         if (ops[k] == decode_pkg::OP_ADDI || ops[k] == decode_pkg::OP_SLTI) begin
            exp_imm = sext16(imm);
         end else begin
            exp_imm = {16'h0000, imm};
         end
         exp_src_a = (ops[k] == decode_pkg::OP_LUI) ? decode_pkg::SRC_A_NONE
                                                     : decode_pkg::SRC_A_RS;
         issue(enc_i(ops[k], 5'd5, 5'd6, imm), pc);
         wait_latch(pc);
         check_eq("rs value", v5, o_ex_rs);
         check_eq("rt value", v6, o_ex_rt);
         check_eq("rs num", 32'd5, 32'(o_ex_rs_num));
         check_eq("rt num", 32'd6, 32'(o_ex_rt_num));
         check_eq("imm", exp_imm, o_ex_imm);
         check_eq("alu op", 32'(exp_alu), 32'(o_ex_alu_op));
         check_eq("src a", 32'(exp_src_a), 32'(o_ex_src_a));
         check_eq("src b", 32'(decode_pkg::SRC_B_IMM), 32'(o_ex_src_b));
         check_eq("dest", 32'(decode_pkg::DEST_RT), 32'(o_ex_dest_sel));
         check_eq("wb en", 32'd1, 32'(o_ex_wb_en));
      end
   endtask

   task automatic branch_redirect();
      logic [31:0] a;
      logic [31:0] pc;
      logic [15:0] off;
      logic [4:0]  rt;
      logic        bne;
      logic        use_equal;
      logic        taken;
      a = $urandom();
      write_reg(5'd7, a);
      write_reg(5'd8, a);
      write_reg(5'd9, ~a);
      for (int k = 0; k < 4; k++) begin
         bne       = k[1];
         use_equal = !k[0];
         taken     = bne ? !use_equal : use_equal;
         rt        = use_equal ? 5'd8 : 5'd9;
         off       = 16'($urandom());
         off[15]   = k[0];   // odd cases branch backwards
         pc        = next_pc();
         test_name = $sformatf("branch %s %s", bne ? "bne" : "beq",
                               use_equal ? "equal" : "unequal");
         issue(enc_i(bne ? decode_pkg::OP_BNE : decode_pkg::OP_BEQ, 5'd7, rt, off), pc);
         check_eq("pc branch", 32'(taken), 32'(o_pc_branch));
         check_eq("pc jump", 32'd0, 32'(o_pc_jump));
         check_eq("brh addr", pc + (sext16(off) << 2), o_brh_addr);
         wait_latch(pc);
         check_eq("wb en", 32'd0, 32'(o_ex_wb_en));
      end
   endtask

   task automatic jump_redirect();
      logic [31:0] pc;
      logic [31:0] v;
      logic [25:0] idx;
      test_name = "jump j";
      idx = 26'($urandom());
      pc  = 32'hA000_0000 | next_pc();
      issue({decode_pkg::OP_J, idx}, pc);
      check_eq("jmp addr", {pc[31:28], idx, 2'b00}, o_jmp_addr);
      check_eq("pc jump", 32'd1, 32'(o_pc_jump));
      check_eq("pc branch", 32'd0, 32'(o_pc_branch));
      wait_latch(pc);
      check_eq("wb en", 32'd0, 32'(o_ex_wb_en));

      test_name = "jump jal";
      idx = 26'($urandom());
      pc  = 32'h5000_0000 | next_pc();
      issue({decode_pkg::OP_JAL, idx}, pc);
      check_eq("jmp addr", {pc[31:28], idx, 2'b00}, o_jmp_addr);
      check_eq("pc jump", 32'd1, 32'(o_pc_jump));
      wait_latch(pc);
      check_eq("dest", 32'(decode_pkg::DEST_RA), 32'(o_ex_dest_sel));
      check_eq("src a", 32'(decode_pkg::SRC_A_PC), 32'(o_ex_src_a));
      check_eq("alu op", 32'(decode_pkg::ALU_JAL), 32'(o_ex_alu_op));
      check_eq("wb en", 32'd1, 32'(o_ex_wb_en));

      test_name = "jump jr";
      v = $urandom();
      write_reg(5'd10, v);
      pc = next_pc();
      issue(enc_r(5'd10, 5'd0, 5'd0, 5'd0, decode_pkg::FN_JR), pc);
      check_eq("jmp addr", v, o_jmp_addr);
      check_eq("pc jump", 32'd1, 32'(o_pc_jump));
      wait_latch(pc);
      check_eq("wb en", 32'd0, 32'(o_ex_wb_en));

      test_name = "jump jalr";
      pc = next_pc();
      issue(enc_r(5'd10, 5'd0, 5'd31, 5'd0, decode_pkg::FN_JALR), pc);
      check_eq("jmp addr", v, o_jmp_addr);
      check_eq("pc jump", 32'd1, 32'(o_pc_jump));
      wait_latch(pc);
      check_eq("src a", 32'(decode_pkg::SRC_A_PC), 32'(o_ex_src_a));
      check_eq("wb en", 32'd1, 32'(o_ex_wb_en));
   endtask

   task automatic special_ops();
      decode_pkg::funct_e shifts [3] = '{decode_pkg::FN_SLL, decode_pkg::FN_SRL,
                                         decode_pkg::FN_SRA};
      logic [31:0] pc;
      logic [4:0]  shamt;
      foreach (shifts[k]) begin
         test_name = $sformatf("special %s", shifts[k].name());
         shamt = 5'($urandom());
         pc    = next_pc();
         issue(enc_r(5'd5, 5'd6, 5'd3, shamt, shifts[k]), pc);
         wait_latch(pc);
         check_eq("src a", 32'(decode_pkg::SRC_A_IMM), 32'(o_ex_src_a));
         check_eq("imm", {27'd0, shamt}, o_ex_imm);
         check_eq("funct", 32'(shifts[k]), 32'(o_ex_funct));
      end

      test_name = "special add";
      pc = next_pc();
      issue(enc_r(5'd5, 5'd6, 5'd4, 5'd0, 6'h20), pc);
      wait_latch(pc);
      check_eq("src a", 32'(decode_pkg::SRC_A_RS), 32'(o_ex_src_a));
      check_eq("src b", 32'(decode_pkg::SRC_B_RT), 32'(o_ex_src_b));
      check_eq("dest", 32'(decode_pkg::DEST_RD), 32'(o_ex_dest_sel));
      check_eq("alu op", 32'(decode_pkg::ALU_FUNC), 32'(o_ex_alu_op));
      check_eq("funct", 32'h20, 32'(o_ex_funct));
      check_eq("rd num", 32'd4, 32'(o_ex_rd_num));
      check_eq("wb en", 32'd1, 32'(o_ex_wb_en));

      test_name = "special nop";
      pc = next_pc();
      issue(32'd0, pc);
      wait_latch(pc);
      check_eq("wb en", 32'd0, 32'(o_ex_wb_en));
   endtask

   task automatic memory_ops();
      logic [31:0] pc;
      logic [15:0] off;
      test_name = "memory lw";
      off = 16'($urandom()) | 16'h8000;   // negative offset
      pc  = next_pc();
      issue(enc_i(decode_pkg::OP_LW, 5'd5, 5'd11, off), pc);
      wait_latch(pc);
      check_eq("mem rd", 32'd1, 32'(o_ex_mem_rd));
      check_eq("mem wr", 32'd0, 32'(o_ex_mem_wr));
      check_eq("wb en", 32'd1, 32'(o_ex_wb_en));
      check_eq("wb from mem", 32'd1, 32'(o_ex_wb_from_mem));
      check_eq("alu op", 32'(decode_pkg::ALU_ADD), 32'(o_ex_alu_op));
      check_eq("imm", sext16(off), o_ex_imm);

      test_name = "memory sw";
      off = 16'($urandom()) & 16'h7fff;
      pc  = next_pc();
      issue(enc_i(decode_pkg::OP_SW, 5'd5, 5'd11, off), pc);
      wait_latch(pc);
      check_eq("mem wr", 32'd1, 32'(o_ex_mem_wr));
      check_eq("mem rd", 32'd0, 32'(o_ex_mem_rd));
      check_eq("wb en", 32'd0, 32'(o_ex_wb_en));
      check_eq("imm", sext16(off), o_ex_imm);
   endtask

   initial begin
      void'($urandom(32'd76));
      value_errs  = 0;
      timing_errs = 0;
      prop_errs   = 0;
      pc_seq      = 32'h0040_0000;
      i_rst       = 1'b1;
      i_pc        = '0;
      i_instr     = '0;
      i_wb_data   = '0;
      i_wb_dst    = '0;
      i_wb_en     = 1'b0;
      for (int i = 0; i < 2; i++) begin
         @(posedge i_clk);
      end
      @(negedge i_clk);
      reset_check();      // releases reset
      imm_alu_ops();
      branch_redirect();
      jump_redirect();
      special_ops();
      memory_ops();
      prop_errs = int'(u_dut.u_props.fail_cnt);
      $display("errors: value %0d, timing %0d, property %0d",
               value_errs, timing_errs, prop_errs);
      if (value_errs + timing_errs + prop_errs == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* flist.f */
+incdir+common
common/decode_pkg.sv
logic/reg_file.sv
decode/decode_control.sv
decode/imm_extend.sv
decode/branch_target.sv
decode/id_ex_latch.sv
decode/decode_stage.sv
testbench/decode_props.sv
testbench/tb_decode.sv

/* run_sim.sh */
#!/bin/sh
# build the decode stage testbench with verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_decode \
   -f flist.f -o tb_decode_sim \
   && ./obj_dir/tb_decode_sim +verilator+error+limit+1000 | tee sim.log \
   || { echo "build or run failed"; exit 1; }
grep -q "^Simulation PASSED$" sim.log && exit 0 || exit 1
